// File: Bender.yml
package:
  name: scanner

sources:
  - src/scannerPkg.sv
  - src/frameLinkIf.sv
  - src/fillCounter.sv
  - src/scanControl.sv
  - src/frameTransmitter.sv
  - src/scannerTop.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/scannerTb.sv

// File: build.f
src/scannerPkg.sv
src/frameLinkIf.sv
src/fillCounter.sv
src/scanControl.sv
src/frameTransmitter.sv
src/scannerTop.sv
tests/clockGen.sv
tests/scannerTb.sv

// File: src/fillCounter.sv
`timescale 1ns/1ps

module fillCounter import scannerPkg::*; #(
	parameter int SlowDiv = 8,
	parameter int FullLevel = 9
) (
	input logic clk,
	input logic rst,
	input logic tickEnable,
	input logic clear,
	output logic [FillWidth-1:0] level
);

	localparam int DivWidth = (SlowDiv > 1) ? $clog2(SlowDiv) : 1;
	localparam logic [DivWidth-1:0] DivLast = DivWidth'(SlowDiv - 1);
	localparam logic [FillWidth-1:0] LevelFull = FillWidth'(FullLevel);

	logic [DivWidth-1:0] divCount; // Enabled cycles since the last fill tick
	logic slowTick; // Stands in for the slow clock edge
	logic atFull;

	assign slowTick = tickEnable && (divCount == DivLast);
	assign atFull = (level == LevelFull);

	// Divider only advances while filling is allowed
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			divCount <= '0;
		end else if (tickEnable) begin
			if (slowTick) begin
				divCount <= '0;
			end else begin
				divCount <= divCount + 1'b1;
			end
		end
	end

	// Saturating fill level
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			level <= '0;
		end else if (slowTick && !atFull) begin
			level <= level + 1'b1;
		end
	end

endmodule

// File: src/frameLinkIf.sv
`timescale 1ns/1ps

interface frameLinkIf import scannerPkg::*; ();

	logic start; // One-cycle request, only while busy is low
	linkOp_t op; // Captured with start
	logic withData; // Append dataByte after the opcode
	logic [7:0] dataByte;
	logic busy; // High from the cycle after start until done
	logic done; // Last cycle of the frame

	modport ctrl (
		output start, op, withData, dataByte,
		input busy, done
	);

	modport tx (
		input start, op, withData, dataByte,
		output busy, done
	);

endinterface

// File: src/frameTransmitter.sv
`timescale 1ns/1ps

module frameTransmitter import scannerPkg::*; (
	input logic clk,
	input logic rst,
	frameLinkIf.tx link,
	output logic serialClk,
	output logic serialData
);

	logic [15:0] shiftReg; // Opcode in the upper byte, MSB out first
	logic [3:0] bitCount; // Bit currently on serialData
	logic [3:0] lastBit; // 7 or 15
	logic phase; // Low half, then high half of a bit

	always_ff @(posedge clk) begin
		if (rst) begin
			link.busy <= 1'b0;
			link.done <= 1'b0;
			serialClk <= 1'b0;
			serialData <= 1'b0;
			bitCount <= '0;
			phase <= 1'b0;
		end else begin
			link.done <= 1'b0;
			if (!link.busy) begin
				if (link.start) begin
					link.busy <= 1'b1;
					bitCount <= '0;
					phase <= 1'b0;
					serialClk <= 1'b0;
					serialData <= link.op[7]; // First bit during the low half
				end
			end else if (!phase) begin
				serialClk <= 1'b1; // Receiver samples here
				phase <= 1'b1;
				if (bitCount == lastBit) begin
					link.done <= 1'b1; // Lines up with the final high half
				end
			end else begin
				serialClk <= 1'b0;
				phase <= 1'b0;
				if (bitCount == lastBit) begin
					link.busy <= 1'b0;
					serialData <= 1'b0;
				end else begin
					bitCount <= bitCount + 1'b1;
					serialData <= shiftReg[14];
				end
			end
		end
	end

	// Payload side, loaded on start and shifted after each full bit
	always_ff @(posedge clk) begin
		if (!link.busy && link.start) begin
			shiftReg <= {link.op, link.dataByte};
			lastBit <= link.withData ? 4'd15 : 4'd7;
		end else if (link.busy && phase) begin
			shiftReg <= {shiftReg[14:0], 1'b0};
		end
	end

endmodule

// File: src/scanControl.sv
`timescale 1ns/1ps

module scanControl import scannerPkg::*; #(
	parameter int FullLevel = 9
) (
	input logic clk,
	input logic rst,
	input peerCode_t peerCode,
	input logic readyForTransfer,
	input logic [FillWidth-1:0] level,
	output logic tickEnable,
	output logic clear,
	output scanState_t state,
	frameLinkIf.ctrl link
);

	localparam logic [FillWidth-1:0] ReadyLevel = FillWidth'(FullLevel - 2);
	localparam logic [FillWidth-1:0] StartLevel = FillWidth'(FullLevel - 1);
	localparam logic [FillWidth-1:0] FullMark = FillWidth'(FullLevel);

	scanState_t nextState;

	// One flag per command so each goes out once per fill
	logic sentReady;
	logic sentStart;
	logic sentFull;
	logic dataIssued; // Data frame requested in this TRANSFER

	logic linkIdle;
	logic needReady;
	logic needStart;
	logic needFull;

	logic issueFrame;
	linkOp_t issueOp;
	logic issueData;

	// A start already in flight counts as busy
	assign linkIdle = !link.busy && !link.start;

	assign needReady = (level == ReadyLevel) && !sentReady;
	assign needStart = (level == StartLevel) && !sentStart;
	assign needFull = (level == FullMark) && !sentFull;

	// Hold the fill while a frame is pending or on the wire
	assign tickEnable = (state == ACTIVE) && linkIdle &&
		!needReady && !needStart && !needFull && !sentFull;

	always_comb begin
		nextState = state;
		issueFrame = 1'b0;
		issueOp = cmdReadyToTransfer;
		issueData = 1'b0;
		clear = 1'b0;
		case (state)
			IDLE: begin
				if (peerCode == peerStart) begin
					nextState = ACTIVE;
				end
			end
			ACTIVE: begin
				if (linkIdle && needReady) begin
					issueFrame = 1'b1;
					issueOp = cmdReadyToTransfer;
				end else if (linkIdle && needStart) begin
					issueFrame = 1'b1;
					issueOp = cmdStartScanning;
				end else if (linkIdle && needFull) begin
					issueFrame = 1'b1;
					issueOp = cmdBufferFull;
				end
				// Decide on the last cycle of the full frame
				if (sentFull && link.done) begin
					nextState = readyForTransfer ? TRANSFER : STANDBY;
				end
			end
			STANDBY: begin
				if (readyForTransfer || (peerCode == peerHalf)) begin
					nextState = TRANSFER;
				end
			end
			TRANSFER: begin
				if (!dataIssued) begin
					if (peerCode == peerHalf) begin
						clear = 1'b1; // Peer wins, drop the data
						nextState = IDLE;
					end else if (linkIdle) begin
						issueFrame = 1'b1;
						issueOp = cmdDataTransfer;
						issueData = 1'b1;
					end
				end else if (link.done) begin
					clear = 1'b1; // Buffer handed over
					nextState = IDLE;
				end
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			sentReady <= 1'b0;
			sentStart <= 1'b0;
			sentFull <= 1'b0;
			dataIssued <= 1'b0;
			link.start <= 1'b0;
		end else begin
			state <= nextState;
			link.start <= issueFrame;
			if (state == IDLE) begin
				// Fresh fill
				sentReady <= 1'b0;
				sentStart <= 1'b0;
				sentFull <= 1'b0;
				dataIssued <= 1'b0;
			end else if (issueFrame) begin
				case (issueOp)
					cmdReadyToTransfer: sentReady <= 1'b1;
					cmdStartScanning: sentStart <= 1'b1;
					cmdBufferFull: sentFull <= 1'b1;
					cmdDataTransfer: dataIssued <= 1'b1;
					default: dataIssued <= dataIssued;
				endcase
			end
		end
	end

	// Frame contents, valid with start
	always_ff @(posedge clk) begin
		if (issueFrame) begin
			link.op <= issueOp;
			link.withData <= issueData;
			link.dataByte <= 8'(level);
		end
	end

endmodule

// File: src/scannerPkg.sv
package scannerPkg;

	// Fill level fits levels up to 15
	localparam int FillWidth = 4;

	typedef enum logic [1:0] {
		IDLE     = 2'd0, // Waiting for a start code
		ACTIVE   = 2'd1, // Filling and reporting thresholds
		STANDBY  = 2'd2, // Full, output driver not ready yet
		TRANSFER = 2'd3  // Sending or dropping the data
	} scanState_t;

	// Frame opcodes as seen by the output driver
	typedef enum logic [7:0] {
		cmdReadyToTransfer = 8'd2, // Sent at FullLevel-2
		cmdStartScanning   = 8'd3, // Sent at FullLevel-1
		cmdBufferFull      = 8'd4, // Sent at FullLevel
		cmdDataTransfer    = 8'd7  // Followed by the level byte
	} linkOp_t;

	// Codes from the peer node
	typedef enum logic [1:0] {
		peerNone  = 2'd0,
		peerStart = 2'd1, // Begin a new fill
		peerHalf  = 2'd2  // Other buffer at half
	} peerCode_t;

endpackage

// File: src/scannerTop.sv
`timescale 1ns/1ps

module scannerTop import scannerPkg::*; #(
	parameter int SlowDiv = 8,
	parameter int FullLevel = 9
) (
	input logic clk,
	input logic rst,
	input peerCode_t peerCode,
	input logic readyForTransfer,
	output logic serialClk,
	output logic serialData,
	output scanState_t state
);

	logic tickEnable;
	logic clear;
	logic [FillWidth-1:0] level;

	frameLinkIf linkBus ();

	fillCounter #(
		.SlowDiv(SlowDiv),
		.FullLevel(FullLevel)
	) fillCounter_inst (
		.clk(clk),
		.rst(rst),
		.tickEnable(tickEnable),
		.clear(clear),
		.level(level)
	);

	scanControl #(
		.FullLevel(FullLevel)
	) scanControl_inst (
		.clk(clk),
		.rst(rst),
		.peerCode(peerCode),
		.readyForTransfer(readyForTransfer),
		.level(level),
		.tickEnable(tickEnable),
		.clear(clear),
		.state(state),
		.link(linkBus.ctrl)
	);

	frameTransmitter frameTransmitter_inst (
		.clk(clk),
		.rst(rst),
		.link(linkBus.tx),
		.serialClk(serialClk),
		.serialData(serialData)
	);

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int HalfPeriod = 20, // 40 ns clock
	parameter int ResetCycles = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0; // Released on a falling edge like the other inputs
	end

endmodule

// File: tests/scannerTb.sv
`timescale 1ns/1ps

module scannerTb import scannerPkg::*; ();

	localparam int SlowDiv = 8; // Same as the DUT defaults
	localparam int FullLevel = 9;
	localparam int ScanCycles = FullLevel * SlowDiv + 4 * 32 + 200;
	localparam int TimeoutCycles = 5 * ScanCycles;
	localparam logic [31:0] Seed = 32'h4df5_0e58;

	typedef logic [7:0] byteList_t[$];

	logic clk;
	logic rst;
	peerCode_t peerCode;
	logic readyForTransfer;
	logic serialClk;
	logic serialData;
	scanState_t state;

	byteList_t rxBytes; // Filled by the serial receiver
	byteList_t expBytes; // Bytes still expected, in order
	bit expIsLevel[$];
	logic [7:0] rxShift;
	int rxBits;
	int closedBits; // Bit count at the end of the last frame
	int lowCycles;
	int cycleCount;
	int mismatches;
	int otherErrors;
	logic [7:0] gotByte;
	logic [7:0] wantByte;
	bit wantLevel;

	clockGen clockGen_inst (.clk(clk), .rst(rst));

	scannerTop scannerTop_inst (
		.clk(clk),
		.rst(rst),
		.peerCode(peerCode),
		.readyForTransfer(readyForTransfer),
		.serialClk(serialClk),
		.serialData(serialData),
		.state(state)
	);

	// Expected frame bytes for one fill with the data frame dropped on a standby abort
	function automatic byteList_t expectedFrames(input bit readyAtFull, input bit halfArrives);
		byteList_t frames;
		frames = {};
		frames.push_back(8'(cmdReadyToTransfer));
		frames.push_back(8'(cmdStartScanning));
		frames.push_back(8'(cmdBufferFull));
		if (readyAtFull || !halfArrives) begin
			frames.push_back(8'(cmdDataTransfer));
			frames.push_back(8'(FullLevel)); // Level byte after the opcode
		end
		return frames;
	endfunction

	task automatic compareOp(input linkOp_t got, input linkOp_t want);
		if (got !== want) begin
			$display("Mismatch at %0t: opcode %0d, expected %0d", $time, got, want);
			mismatches++;
		end
	endtask

	task automatic compareLevel(input logic [FillWidth-1:0] got,
		input logic [FillWidth-1:0] want);
		if (got !== want) begin
			$display("Mismatch at %0t: level byte %0d, expected %0d", $time, got, want);
			mismatches++;
		end
	endtask

	task automatic compareState(input scanState_t got, input scanState_t want, input string where);
		if (got !== want) begin
			$display("Mismatch at %0t: state %s %s, expected %s", $time, got.name(), where,
				want.name());
			mismatches++;
		end
	endtask

	task automatic pushExpected(input bit readyAtFull, input bit halfArrives);
		byteList_t frames;
		frames = expectedFrames(readyAtFull, halfArrives);
		foreach (frames[i]) begin
			expBytes.push_back(frames[i]);
			expIsLevel.push_back(i > 0 && frames[i-1] == 8'(cmdDataTransfer));
		end
	endtask

	task automatic waitBytesLeft(input int left);
		int waited;
		waited = 0;
		while (expBytes.size() > left && waited < ScanCycles) begin
			@(negedge clk);
			waited++;
		end
		if (expBytes.size() > left) begin
			$display("Missing frame: %0d expected bytes never arrived by %0t",
				expBytes.size() - left, $time);
			otherErrors++;
			expBytes = {};
			expIsLevel = {};
		end
	endtask

	task automatic waitForState(input scanState_t want);
		int waited;
		waited = 0;
		while (state !== want && waited < ScanCycles) begin
			@(negedge clk);
			waited++;
		end
	endtask

	// Serial line must stay low while nothing is due
	task automatic quietCycles(input int count, input scanState_t want, input string where);
		repeat (count) begin
			@(negedge clk);
			if (serialClk !== 1'b0 || serialData !== 1'b0) begin
				$display("Serial line active at %0t while %s", $time, where);
				otherErrors++;
			end
		end
		compareState(state, want, where);
	endtask

	task automatic startScan();
		peerCode = peerStart;
		@(negedge clk);
		peerCode = peerNone;
	endtask

	// Receiver shifting in MSB first
	always @(posedge serialClk) begin
		rxShift = {rxShift[6:0], serialData};
		rxBits = rxBits + 1;
		if (rxBits % 8 == 0) begin
			rxBytes.push_back(rxShift);
		end
	end

	// More than 2 low cycles closes a frame
	always @(negedge clk) begin
		lowCycles = serialClk ? 0 : lowCycles + 1;
		if (lowCycles > 2 && rxBits != closedBits) begin
			if (rxBits - closedBits != 8 && rxBits - closedBits != 16) begin
				$display("Frame of %0d bits received at %0t, expected 8 or 16",
					rxBits - closedBits, $time);
				otherErrors++;
			end
			closedBits = rxBits;
		end
	end

	always @(negedge clk) begin
		if (rxBytes.size() > 0) begin
			gotByte = rxBytes.pop_front();
			if (expBytes.size() == 0) begin
				$display("Unexpected frame byte %0d received at %0t", gotByte, $time);
				otherErrors++;
			end else begin
				wantByte = expBytes.pop_front();
				wantLevel = expIsLevel.pop_front();
				if (wantLevel) begin
					if (gotByte[7:FillWidth] !== '0) begin
						$display("Mismatch at %0t: level byte %0d has upper bits set",
							$time, gotByte);
						mismatches++;
					end
					compareLevel(gotByte[FillWidth-1:0], wantByte[FillWidth-1:0]);
				end else begin
					compareOp(linkOp_t'(gotByte), linkOp_t'(wantByte));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
			$display("Errors: %0d mismatches, %0d other", mismatches, otherErrors);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		peerCode = peerNone;
		readyForTransfer = 1'b0;
		void'($urandom(Seed));
		wait (rst === 1'b0);
		@(negedge clk);
		compareState(state, IDLE, "after reset");
		quietCycles(5 + $urandom % 16, IDLE, "idle after reset");

		// Driver ready at full so data goes out at once
		readyForTransfer = 1'b1;
		pushExpected(1'b1, 1'b0);
		startScan();
		waitBytesLeft(0);
		waitForState(IDLE);
		compareState(state, IDLE, "after data transfer");
		readyForTransfer = 1'b0;
		quietCycles(5 + $urandom % 16, IDLE, "idle after transfer");

		// Late driver waits in standby
		pushExpected(1'b0, 1'b0);
		startScan();
		waitBytesLeft(2);
		waitForState(STANDBY);
		compareState(state, STANDBY, "after buffer full");
		quietCycles(10 + $urandom % 51, STANDBY, "waiting in standby");
		readyForTransfer = 1'b1;
		waitBytesLeft(0);
		waitForState(IDLE);
		compareState(state, IDLE, "after late transfer");
		readyForTransfer = 1'b0;
		quietCycles(5 + $urandom % 16, IDLE, "idle after late transfer");

		// Peer half during standby drops the data
		pushExpected(1'b0, 1'b1);
		startScan();
		waitBytesLeft(0);
		waitForState(STANDBY);
		compareState(state, STANDBY, "before peer half");
		quietCycles(10 + $urandom % 51, STANDBY, "waiting in standby");
		peerCode = peerHalf;
		repeat (3) @(negedge clk);
		peerCode = peerNone;
		waitForState(IDLE);
		compareState(state, IDLE, "after peer half");
		quietCycles(5 + $urandom % 16, IDLE, "idle after peer half");

		// Cleared buffer starts again from the first threshold
		readyForTransfer = 1'b1;
		pushExpected(1'b1, 1'b0);
		startScan();
		waitBytesLeft(0);
		waitForState(IDLE);
		compareState(state, IDLE, "after refill transfer");
		readyForTransfer = 1'b0;
		quietCycles(8, IDLE, "idle at end");

		$display("Errors: %0d mismatches, %0d other", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
